// ==== source/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

  ////////////////////////////////////////////////////////////
  // widths.
  ////////////////////////////////////////////////////////////

  localparam int NB_WORD      = 32;
  localparam int NB_REG_ADDR  = 5;
  localparam int NB_OPCODE    = 6;
  localparam int NB_SIZE_TYPE = 3;
  localparam int NB_SHAMT     = 5;
  localparam int NB_IMM       = 16;
  localparam int NB_TARGET    = 26;
  localparam int N_REGS       = 2 ** NB_REG_ADDR;

  ////////////////////////////////////////////////////////////
  // opcodes and encodings.
  ////////////////////////////////////////////////////////////

  localparam logic [NB_OPCODE-1:0] RTYPE_OPCODE = 6'b000000;
  localparam logic [NB_OPCODE-1:0] J_OPCODE     = 6'b000010;
  localparam logic [NB_OPCODE-1:0] BEQ_OPCODE   = 6'b000100;
  localparam logic [NB_OPCODE-1:0] BNE_OPCODE   = 6'b000101;
  localparam logic [NB_OPCODE-1:0] ADDI_OPCODE  = 6'b001000;
  localparam logic [NB_OPCODE-1:0] ANDI_OPCODE  = 6'b001100;
  localparam logic [NB_OPCODE-1:0] LW_OPCODE    = 6'b100011;
  localparam logic [NB_OPCODE-1:0] SW_OPCODE    = 6'b101011;

  localparam logic [NB_SIZE_TYPE-1:0] COMPLETE_WORD = 3'b111;

  typedef enum logic [1:0] {
    SIGNED_EXTENSION_MODE   = 2'b00,
    UNSIGNED_EXTENSION_MODE = 2'b01
  } ext_mode_e;

  typedef enum logic {
    RT_ALU_SRC        = 1'b0,
    IMMEDIATE_ALU_SRC = 1'b1
  } alu_src_e;

  ////////////////////////////////////////////////////////////
  // instruction word and stage bundles.
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [NB_OPCODE-1:0]   opcode;
    logic [NB_REG_ADDR-1:0] rs;
    logic [NB_REG_ADDR-1:0] rt;
    logic [NB_REG_ADDR-1:0] rd;
    logic [NB_SHAMT-1:0]    shamt;
    logic [NB_OPCODE-1:0]   funct;
  } r_fmt_t;

  typedef struct packed {
    logic [NB_OPCODE-1:0]   opcode;
    logic [NB_REG_ADDR-1:0] rs;
    logic [NB_REG_ADDR-1:0] rt;
    logic [NB_IMM-1:0]      imm16;
  } i_fmt_t;

  typedef struct packed {
    logic [NB_OPCODE-1:0] opcode;
    logic [NB_TARGET-1:0] target26;
  } j_fmt_t;

  // same 32 bits, decoded per format.
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    j_fmt_t j_fmt;
  } instr_u;

  typedef struct packed {
    alu_src_e               alu_src;
    logic                   mem_read;
    logic                   mem_write;
    logic                   mem_to_reg;
    logic                   reg_write;
    logic                   branch;
    logic                   jump;
    logic                   signed_load;   // loads only.
    ext_mode_e              ext_mode;
    logic [NB_SIZE_TYPE-1:0] word_size;
    logic [NB_REG_ADDR-1:0] reg_dst_addr;
  } ctrl_t;

  localparam ctrl_t CTRL_BUBBLE = '{
    alu_src:      RT_ALU_SRC,
    mem_read:     1'b0,
    mem_write:    1'b0,
    mem_to_reg:   1'b0,
    reg_write:    1'b0,
    branch:       1'b0,
    jump:         1'b0,
    signed_load:  1'b0,
    ext_mode:     SIGNED_EXTENSION_MODE,
    word_size:    COMPLETE_WORD,
    reg_dst_addr: '0
  };

  typedef struct packed {
    ctrl_t                  ctrl;
    logic [NB_WORD-1:0]     rs_data;
    logic [NB_WORD-1:0]     rt_data;
    logic [NB_WORD-1:0]     imm_ext;
    logic [NB_WORD-1:0]     branch_target;
    logic [NB_WORD-1:0]     jump_target;
    logic [NB_OPCODE-1:0]   funct;
    logic [NB_OPCODE-1:0]   opcode;    // EX needs it for beq vs bne.
    logic [NB_REG_ADDR-1:0] rs_addr;
    logic [NB_REG_ADDR-1:0] rt_addr;
  } id_ex_t;

endpackage

`default_nettype wire

// ==== source/control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_unit (
  input  wire mips_pkg::instr_u i_instruction,
  input  wire logic             i_flush,
  output mips_pkg::ctrl_t       o_ctrl
);

  import mips_pkg::*;

  logic [NB_OPCODE-1:0]   opcode;
  logic [NB_REG_ADDR-1:0] rt;
  logic [NB_REG_ADDR-1:0] rd;

  assign opcode = i_instruction.r_fmt.opcode;
  assign rt     = i_instruction.r_fmt.rt;
  assign rd     = i_instruction.r_fmt.rd;

  ////////////////////////////////////////////////////////////
  // decode table.
  ////////////////////////////////////////////////////////////

  always_comb begin
    o_ctrl = CTRL_BUBBLE;
    if (!i_flush) begin
      case (opcode)
        RTYPE_OPCODE: begin
          o_ctrl.alu_src      = RT_ALU_SRC;
          o_ctrl.ext_mode     = SIGNED_EXTENSION_MODE;
          o_ctrl.mem_read     = 1'b0;
          o_ctrl.mem_write    = 1'b0;
          o_ctrl.reg_write    = 1'b1;
          o_ctrl.branch       = 1'b0;
          o_ctrl.jump         = 1'b0;
          o_ctrl.word_size    = '0;
          o_ctrl.reg_dst_addr = rd;
        end

        ADDI_OPCODE: begin
          o_ctrl.alu_src      = IMMEDIATE_ALU_SRC;
          o_ctrl.ext_mode     = SIGNED_EXTENSION_MODE;
          o_ctrl.mem_read     = 1'b0;
          o_ctrl.mem_write    = 1'b0;
          o_ctrl.reg_write    = 1'b1;
          o_ctrl.branch       = 1'b0;
          o_ctrl.jump         = 1'b0;
          o_ctrl.word_size    = '0;
          o_ctrl.reg_dst_addr = rt;
        end

        // logical immediates are zero extended.
        ANDI_OPCODE: begin
          o_ctrl.alu_src      = IMMEDIATE_ALU_SRC;
          o_ctrl.ext_mode     = UNSIGNED_EXTENSION_MODE;
          o_ctrl.mem_read     = 1'b0;
          o_ctrl.mem_write    = 1'b0;
          o_ctrl.reg_write    = 1'b1;
          o_ctrl.branch       = 1'b0;
          o_ctrl.jump         = 1'b0;
          o_ctrl.word_size    = '0;
          o_ctrl.reg_dst_addr = rt;
        end

        BEQ_OPCODE, BNE_OPCODE: begin
          o_ctrl.alu_src  = RT_ALU_SRC;
          o_ctrl.ext_mode = SIGNED_EXTENSION_MODE;
          o_ctrl.branch   = 1'b1;
        end

        J_OPCODE: begin
          o_ctrl.jump = 1'b1;
        end

        SW_OPCODE: begin
          o_ctrl.alu_src   = IMMEDIATE_ALU_SRC;
          o_ctrl.mem_read  = 1'b0;
          o_ctrl.mem_write = 1'b1;
          o_ctrl.ext_mode  = SIGNED_EXTENSION_MODE;
          o_ctrl.word_size = COMPLETE_WORD;
        end

        // load result goes to rt.
        LW_OPCODE: begin
          o_ctrl.alu_src      = IMMEDIATE_ALU_SRC;
          o_ctrl.mem_read     = 1'b1;
          o_ctrl.mem_write    = 1'b0;
          o_ctrl.mem_to_reg   = 1'b1;
          o_ctrl.reg_write    = 1'b1;
          o_ctrl.signed_load  = 1'b1;
          o_ctrl.reg_dst_addr = rt;
        end

        default: begin
          o_ctrl = CTRL_BUBBLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  wire logic                                 i_clk,
  input  wire logic                                 i_arst_n,
  input  wire logic [mips_pkg::NB_REG_ADDR-1:0]     i_rs_addr,
  input  wire logic [mips_pkg::NB_REG_ADDR-1:0]     i_rt_addr,
  input  wire logic                                 i_wr_en,
  input  wire logic [mips_pkg::NB_REG_ADDR-1:0]     i_wr_addr,
  input  wire logic [mips_pkg::NB_WORD-1:0]         i_wr_data,
  output logic      [mips_pkg::NB_WORD-1:0]         o_rs_data,
  output logic      [mips_pkg::NB_WORD-1:0]         o_rt_data
);

  import mips_pkg::*;

  logic [NB_WORD-1:0] regs [N_REGS];
  logic               wr_valid;

  // register zero is never written.
  assign wr_valid = i_wr_en && (i_wr_addr != '0);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < N_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_valid) begin
      regs[i_wr_addr] <= i_wr_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // read ports with write-through.
  ////////////////////////////////////////////////////////////

  function automatic logic [NB_WORD-1:0] read_port(
    input logic [NB_REG_ADDR-1:0] addr
  );
    logic [NB_WORD-1:0] data;
    if (addr == '0) begin
      data = '0;
    end else if (wr_valid && (addr == i_wr_addr)) begin
      data = i_wr_data;
    end else begin
      data = regs[addr];
    end
    return data;
  endfunction

  always_comb begin
    o_rs_data = read_port(i_rs_addr);
    o_rt_data = read_port(i_rt_addr);
  end

endmodule

`default_nettype wire

// ==== source/immediate_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module immediate_unit (
  input  wire mips_pkg::instr_u                i_instruction,
  input  wire logic [mips_pkg::NB_WORD-1:0]    i_pc_plus4,
  input  wire mips_pkg::ext_mode_e             i_ext_mode,
  output logic      [mips_pkg::NB_WORD-1:0]    o_imm_ext,
  output logic      [mips_pkg::NB_WORD-1:0]    o_branch_target,
  output logic      [mips_pkg::NB_WORD-1:0]    o_jump_target
);

  import mips_pkg::*;

  logic [NB_IMM-1:0]    imm16;
  logic [NB_TARGET-1:0] target26;
  logic [NB_WORD-1:0]   imm_signed;
  logic [NB_WORD-1:0]   imm_unsigned;

  assign imm16    = i_instruction.i_fmt.imm16;
  assign target26 = i_instruction.j_fmt.target26;

  assign imm_signed   = {{(NB_WORD - NB_IMM){imm16[NB_IMM-1]}}, imm16};
  assign imm_unsigned = {{(NB_WORD - NB_IMM){1'b0}}, imm16};

  always_comb begin
    case (i_ext_mode)
      UNSIGNED_EXTENSION_MODE: o_imm_ext = imm_unsigned;
      default:                 o_imm_ext = imm_signed;
    endcase
  end

  // branch offset is always signed, independent of the mode.
  assign o_branch_target = i_pc_plus4 + {imm_signed[NB_WORD-3:0], 2'b00};

  // pseudo-direct jump within the current 256 MB region.
  assign o_jump_target = {i_pc_plus4[NB_WORD-1 -: 4], target26, 2'b00};

endmodule

`default_nettype wire

// ==== source/id_ex_register.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_ex_register (
  input  wire logic             i_clk,
  input  wire logic             i_arst_n,
  input  wire mips_pkg::id_ex_t i_id_ex,
  output mips_pkg::id_ex_t      o_id_ex
);

  import mips_pkg::*;

  ////////////////////////////////////////////////////////////
  // ID/EX boundary.
  ////////////////////////////////////////////////////////////

  // control leaves reset as a bubble, data as zero.
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_id_ex      <= '0;
      o_id_ex.ctrl <= CTRL_BUBBLE;
    end else begin
      o_id_ex <= i_id_ex;
    end
  end

endmodule

`default_nettype wire

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  wire logic                                 i_clk,
  input  wire logic                                 i_arst_n,
  input  wire mips_pkg::instr_u                     i_instruction,
  input  wire logic [mips_pkg::NB_WORD-1:0]         i_pc_plus4,
  input  wire logic                                 i_flush,
  input  wire logic                                 i_wb_write,
  input  wire logic [mips_pkg::NB_REG_ADDR-1:0]     i_wb_addr,
  input  wire logic [mips_pkg::NB_WORD-1:0]         i_wb_data,
  output mips_pkg::id_ex_t                          o_id_ex
);

  import mips_pkg::*;

  ctrl_t              ctrl_next;
  logic [NB_WORD-1:0] rs_data;
  logic [NB_WORD-1:0] rt_data;
  logic [NB_WORD-1:0] imm_ext;
  logic [NB_WORD-1:0] branch_target;
  logic [NB_WORD-1:0] jump_target;
  id_ex_t             id_ex_next;

  control_unit u_control_unit (
    .i_instruction (i_instruction),
    .i_flush       (i_flush),
    .o_ctrl        (ctrl_next)
  );

  register_file u_register_file (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_rs_addr (i_instruction.i_fmt.rs),
    .i_rt_addr (i_instruction.i_fmt.rt),
    .i_wr_en   (i_wb_write),
    .i_wr_addr (i_wb_addr),
    .i_wr_data (i_wb_data),
    .o_rs_data (rs_data),
    .o_rt_data (rt_data)
  );

  immediate_unit u_immediate_unit (
    .i_instruction   (i_instruction),
    .i_pc_plus4      (i_pc_plus4),
    .i_ext_mode      (ctrl_next.ext_mode),
    .o_imm_ext       (imm_ext),
    .o_branch_target (branch_target),
    .o_jump_target   (jump_target)
  );

  // pack the stage result.
  always_comb begin
    id_ex_next.ctrl          = ctrl_next;
    id_ex_next.rs_data       = rs_data;
    id_ex_next.rt_data       = rt_data;
    id_ex_next.imm_ext       = imm_ext;
    id_ex_next.branch_target = branch_target;
    id_ex_next.jump_target   = jump_target;
    id_ex_next.funct         = i_instruction.r_fmt.funct;
    id_ex_next.opcode        = i_instruction.i_fmt.opcode;
    id_ex_next.rs_addr       = i_instruction.i_fmt.rs;
    id_ex_next.rt_addr       = i_instruction.i_fmt.rt;
  end

  id_ex_register u_id_ex_register (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_id_ex  (id_ex_next),
    .o_id_ex  (o_id_ex)
  );

endmodule

`default_nettype wire

// ==== bench/decode_stage_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage_assert (
  input wire logic             i_clk,
  input wire logic             i_arst_n,
  input wire logic             i_flush,
  input wire mips_pkg::id_ex_t i_id_ex
);

  import mips_pkg::*;

  ctrl_t ctrl;

  assign ctrl = i_id_ex.ctrl;

  // a flushed cycle leaves a bubble behind it.
  a_flush_bubble : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
      i_flush |=> (ctrl == CTRL_BUBBLE)
  ) else $error("control is not a bubble one cycle after flush");

  a_mem_exclusive : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
      !(ctrl.mem_read && ctrl.mem_write)
  ) else $error("mem_read and mem_write are set together");

  // jumps never write back.
  a_jump_no_write : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
      ctrl.jump |-> !ctrl.reg_write
  ) else $error("jump decoded with reg_write set");

endmodule

bind decode_stage decode_stage_assert u_decode_stage_assert (
  .i_clk    (i_clk),
  .i_arst_n (i_arst_n),
  .i_flush  (i_flush),
  .i_id_ex  (o_id_ex)
);

`default_nettype wire

// ==== bench/decode_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb;

  import mips_pkg::*;

  localparam real T_HALF     = 2.0;
  localparam real T_DRIVE    = 0.5;
  localparam int  N_RST      = 4;
  localparam int  N_WAIT_MAX = 64;

  typedef struct packed {
    instr_u                 instr;
    logic [NB_WORD-1:0]     pc_plus4;
    logic                   flush;
    logic                   wb_write;
    logic [NB_REG_ADDR-1:0] wb_addr;
    logic [NB_WORD-1:0]     wb_data;
  } stim_t;

  logic                   i_clk;
  logic                   i_arst_n;
  instr_u                 i_instruction;
  logic [NB_WORD-1:0]     i_pc_plus4;
  logic                   i_flush;
  logic                   i_wb_write;
  logic [NB_REG_ADDR-1:0] i_wb_addr;
  logic [NB_WORD-1:0]     i_wb_data;
  id_ex_t                 o_id_ex;

  logic [NB_WORD-1:0] shadow [N_REGS];
  stim_t              stim_q [$];
  string              name_q [$];
  integer             seed;

  decode_stage u_decode_stage (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_instruction (i_instruction),
    .i_pc_plus4    (i_pc_plus4),
    .i_flush       (i_flush),
    .i_wb_write    (i_wb_write),
    .i_wb_addr     (i_wb_addr),
    .i_wb_data     (i_wb_data),
    .o_id_ex       (o_id_ex)
  );

  initial begin
    i_clk = 1'b0;
    forever #T_HALF i_clk = ~i_clk;
  end

  initial begin
    i_arst_n = 1'b0;
    repeat (N_RST) @(posedge i_clk);
    #T_DRIVE;
    i_arst_n = 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // encoders and reference model.
  ////////////////////////////////////////////////////////////

  function automatic instr_u encode_r(input logic [4:0] rs, input logic [4:0] rt,
                                      input logic [4:0] rd, input logic [5:0] funct);
    return {RTYPE_OPCODE, rs, rt, rd, 5'd0, funct};
  endfunction

  function automatic instr_u encode_i(input logic [5:0] op, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic instr_u encode_j(input logic [5:0] op, input logic [25:0] target);
    return {op, target};
  endfunction

  function automatic ctrl_t bubble_ctrl();
    ctrl_t c;
    c           = '0;
    c.alu_src   = RT_ALU_SRC;
    c.ext_mode  = SIGNED_EXTENSION_MODE;
    c.word_size = COMPLETE_WORD;
    return c;
  endfunction

  function automatic ctrl_t model_ctrl(input instr_u instr, input logic flush);
    ctrl_t c;
    c = bubble_ctrl();
    if (!flush) begin
      case (instr.i_fmt.opcode)
        RTYPE_OPCODE: begin
          c.reg_write    = 1'b1;
          c.word_size    = '0;
          c.reg_dst_addr = instr.r_fmt.rd;
        end
        ADDI_OPCODE, ANDI_OPCODE: begin
          c.alu_src      = IMMEDIATE_ALU_SRC;
          c.reg_write    = 1'b1;
          c.word_size    = '0;
          c.reg_dst_addr = instr.i_fmt.rt;
          if (instr.i_fmt.opcode == ANDI_OPCODE) begin
            c.ext_mode = UNSIGNED_EXTENSION_MODE;
          end
        end
        BEQ_OPCODE, BNE_OPCODE: c.branch = 1'b1;
        J_OPCODE:               c.jump = 1'b1;
        SW_OPCODE: begin
          c.alu_src   = IMMEDIATE_ALU_SRC;
          c.mem_write = 1'b1;
        end
        LW_OPCODE: begin
          c.alu_src      = IMMEDIATE_ALU_SRC;
          c.mem_read     = 1'b1;
          c.mem_to_reg   = 1'b1;
          c.reg_write    = 1'b1;
          c.signed_load  = 1'b1;
          c.reg_dst_addr = instr.i_fmt.rt;
        end
        default: begin
        end
      endcase
    end
    return c;
  endfunction

  // a same-cycle write-back is seen by the read.
  function automatic logic [NB_WORD-1:0] model_read(input logic [4:0] addr, input stim_t s);
    if (addr == '0) begin
      return '0;
    end
    if (s.wb_write && (s.wb_addr == addr)) begin
      return s.wb_data;
    end
    return shadow[addr];
  endfunction

  function automatic id_ex_t model_id_ex(input stim_t s);
    id_ex_t             e;
    logic [NB_WORD-1:0] imm_s;
    imm_s           = {{16{s.instr.i_fmt.imm16[15]}}, s.instr.i_fmt.imm16};
    e.ctrl          = model_ctrl(s.instr, s.flush);
    e.rs_data       = model_read(s.instr.i_fmt.rs, s);
    e.rt_data       = model_read(s.instr.i_fmt.rt, s);
    e.imm_ext       = (e.ctrl.ext_mode == UNSIGNED_EXTENSION_MODE) ?
                      {16'h0000, s.instr.i_fmt.imm16} : imm_s;
    e.branch_target = s.pc_plus4 + (imm_s << 2);
    e.jump_target   = {s.pc_plus4[31:28], s.instr.j_fmt.target26, 2'b00};
    e.funct         = s.instr.r_fmt.funct;
    e.opcode        = s.instr.i_fmt.opcode;
    e.rs_addr       = s.instr.i_fmt.rs;
    e.rt_addr       = s.instr.i_fmt.rt;
    return e;
  endfunction

  ////////////////////////////////////////////////////////////
  // checks.
  ////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_ctrl(input string test, input ctrl_t expected, input ctrl_t actual);
    if (actual !== expected) begin
      $display("MISMATCH %s ctrl expected %h actual %h", test, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_word(input string test, input string field,
                            input logic [NB_WORD-1:0] expected,
                            input logic [NB_WORD-1:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s %s expected %h actual %h", test, field, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_stage(input string test, input id_ex_t expected);
    check_ctrl(test, expected.ctrl, o_id_ex.ctrl);
    check_word(test, "rs_data", expected.rs_data, o_id_ex.rs_data);
    check_word(test, "rt_data", expected.rt_data, o_id_ex.rt_data);
    check_word(test, "imm_ext", expected.imm_ext, o_id_ex.imm_ext);
    check_word(test, "branch_target", expected.branch_target, o_id_ex.branch_target);
    check_word(test, "jump_target", expected.jump_target, o_id_ex.jump_target);
    // opcode, funct and both source addresses in one word.
    check_word(test, "fields",
               {10'd0, expected.opcode, expected.funct, expected.rs_addr, expected.rt_addr},
               {10'd0, o_id_ex.opcode, o_id_ex.funct, o_id_ex.rs_addr, o_id_ex.rt_addr});
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus.
  ////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge i_clk);
    #T_DRIVE;
  endtask

  task automatic add_row(input string name, input instr_u instr,
                         input logic [NB_WORD-1:0] pc, input logic flush);
    stim_t s;
    s          = '0;
    s.instr    = instr;
    s.pc_plus4 = pc;
    s.flush    = flush;
    stim_q.push_back(s);
    name_q.push_back(name);
  endtask

  task automatic add_write_back(input logic [4:0] addr, input logic [NB_WORD-1:0] data);
    stim_t s;
    s          = stim_q.pop_back();
    s.wb_write = 1'b1;
    s.wb_addr  = addr;
    s.wb_data  = data;
    stim_q.push_back(s);
  endtask

  task automatic load_table();
    add_row("rtype_add", encode_r(5'd1, 5'd2, 5'd3, 6'h20), 32'h0000_1004, 1'b0);
    add_row("addi_neg", encode_i(ADDI_OPCODE, 5'd4, 5'd5, 16'hfff0), 32'h0000_2000, 1'b0);
    add_row("andi_zext", encode_i(ANDI_OPCODE, 5'd4, 5'd6, 16'hfff0), 32'h0000_2004, 1'b0);
    add_row("lw_neg", encode_i(LW_OPCODE, 5'd7, 5'd8, 16'h8004), 32'h0000_2008, 1'b0);
    add_row("sw_pos", encode_i(SW_OPCODE, 5'd9, 5'd10, 16'h0010), 32'h0000_200c, 1'b0);
    add_row("beq_fwd", encode_i(BEQ_OPCODE, 5'd11, 5'd12, 16'h0004), 32'h0040_0010, 1'b0);
    add_row("bne_back", encode_i(BNE_OPCODE, 5'd13, 5'd14, 16'hfffc), 32'h0040_0100, 1'b0);
    add_row("beq_far_back", encode_i(BEQ_OPCODE, 5'd1, 5'd2, 16'h8000), 32'h1000_0000, 1'b0);
    add_row("j_low", encode_j(J_OPCODE, 26'h012_3456), 32'h0000_0404, 1'b0);
    add_row("j_high", encode_j(J_OPCODE, 26'h3ff_ffff), 32'ha000_0008, 1'b0);
    add_row("unknown_op", encode_i(6'h3f, 5'd1, 5'd2, 16'h1234), 32'h0000_3000, 1'b0);
    add_row("zero_write", encode_r(5'd0, 5'd0, 5'd7, 6'h20), 32'h0000_3004, 1'b0);
    add_write_back(5'd0, 32'hdead_beef);
    add_row("zero_after", encode_i(ADDI_OPCODE, 5'd0, 5'd3, 16'h0001), 32'h0000_3008, 1'b0);
    add_row("wt_rs", encode_r(5'd15, 5'd16, 5'd17, 6'h21), 32'h0000_300c, 1'b0);
    add_write_back(5'd15, 32'h1234_5678);
    add_row("wt_rt", encode_i(SW_OPCODE, 5'd15, 5'd16, 16'h0010), 32'h0000_3010, 1'b0);
    add_write_back(5'd16, 32'h0bad_f00d);
    add_row("flush_lw", encode_i(LW_OPCODE, 5'd3, 5'd4, 16'hff00), 32'h0000_3014, 1'b1);
    add_row("after_flush", encode_i(ANDI_OPCODE, 5'd5, 5'd6, 16'h8001), 32'h0000_3018, 1'b0);
  endtask

  initial begin
    id_ex_t expected;
    int     waited;

    seed          = 32'hb87f;
    i_instruction = '0;
    i_pc_plus4    = '0;
    i_flush       = 1'b0;
    i_wb_write    = 1'b0;
    i_wb_addr     = '0;
    i_wb_data     = '0;
    shadow[0]     = '0;
    load_table();

    waited = 0;
    while (i_arst_n !== 1'b1) begin
      @(negedge i_clk);
      waited++;
      if (waited > N_WAIT_MAX) begin
        $display("reset was never released");
        abort_run();
      end
    end
    check_ctrl("reset_release", bubble_ctrl(), o_id_ex.ctrl);
    check_word("reset_release", "rs_data", '0, o_id_ex.rs_data);
    next_cycle();

    // preload registers 1 to 31.
    for (int r = 1; r < N_REGS; r++) begin
      i_wb_write = 1'b1;
      i_wb_addr  = NB_REG_ADDR'(r);
      i_wb_data  = $random(seed);
      shadow[r]  = i_wb_data;
      next_cycle();
    end

    for (int k = 0; k < stim_q.size(); k++) begin
      i_instruction = stim_q[k].instr;
      i_pc_plus4    = stim_q[k].pc_plus4;
      i_flush       = stim_q[k].flush;
      i_wb_write    = stim_q[k].wb_write;
      i_wb_addr     = stim_q[k].wb_addr;
      i_wb_data     = stim_q[k].wb_data;
      expected      = model_id_ex(stim_q[k]);
      next_cycle();
      if (stim_q[k].wb_write && (stim_q[k].wb_addr != '0)) begin
        shadow[stim_q[k].wb_addr] = stim_q[k].wb_data;
      end
      check_stage(name_q[k], expected);
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
source/mips_pkg.sv
source/control_unit.sv
source/register_file.sv
source/immediate_unit.sv
source/id_ex_register.sv
source/decode_stage.sv
bench/decode_stage_assert.sv
bench/decode_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
  --top-module decode_stage_tb \
  --Mdir "$BUILD_DIR" \
  -f files.f

sim_status=0
"./$BUILD_DIR/Vdecode_stage_tb" > "$LOG" 2>&1 || sim_status=$?
cat "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
  echo "testbench reported failure"
  exit 1
fi
if [ "$sim_status" -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi
echo "run completed without failure"
